// File: ctrl_enc.f
logic/enc_pkg.sv
logic/enc_debounce.sv
logic/enc_quad_counter.sv
logic/enc_period_meter.sv
logic/enc_reg_file.sv
logic/ctrl_enc.sv
testbench/tb_clock_gen.sv
testbench/tb_ctrl_enc.sv

// File: logic/ctrl_enc.sv
// quadrature encoder interface
// filters, counters and meters per channel with register port

module ctrl_enc #(
    parameter int NUM_CHAN        = 4,      // 1 to 16
    parameter int DEBOUNCE_CYCLES = 4,      // filter hold length
    parameter int FREQ_WINDOW     = 1024    // frequency window in cycles
) (
    input  logic                sysclk,
    input  logic                reset,
    input  logic [NUM_CHAN-1:0] enc_a,      // raw encoder A lines
    input  logic [NUM_CHAN-1:0] enc_b,      // raw encoder B lines
    input  enc_pkg::reg_addr_t  reg_raddr,
    output enc_pkg::reg_data_t  reg_rdata,
    input  enc_pkg::reg_addr_t  reg_waddr,
    input  enc_pkg::reg_data_t  reg_wdata,
    input  logic                reg_wen
);
    import enc_pkg::*;

    // ------------------------------------------------------------------------
    // per-channel wires

    logic   [NUM_CHAN-1:0] enc_a_filt;
    logic   [NUM_CHAN-1:0] enc_b_filt;
    logic   [NUM_CHAN-1:0] step;        // one cycle per decoded step
    logic   [NUM_CHAN-1:0] dir;         // step direction
    logic   [NUM_CHAN-1:0] load;        // preload strobe
    count_t [NUM_CHAN-1:0] preload;
    quad_t  [NUM_CHAN-1:0] position;
    meas_t  [NUM_CHAN-1:0] period;
    meas_t  [NUM_CHAN-1:0] frequency;

    // ------------------------------------------------------------------------
    // channel datapath

    for (genvar ch = 0; ch < NUM_CHAN; ch++)
    begin : g_chan
        enc_debounce #(
            .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) filter_a (
            .sysclk    (sysclk),
            .reset     (reset),
            .line_raw  (enc_a[ch]),
            .line_filt (enc_a_filt[ch])
        );

        enc_debounce #(
            .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) filter_b (
            .sysclk    (sysclk),
            .reset     (reset),
            .line_raw  (enc_b[ch]),
            .line_filt (enc_b_filt[ch])
        );

        enc_quad_counter quad (
            .sysclk   (sysclk),
            .reset    (reset),
            .a_filt   (enc_a_filt[ch]),
            .b_filt   (enc_b_filt[ch]),
            .load     (load[ch]),
            .preload  (preload[ch]),
            .position (position[ch]),
            .step     (step[ch]),
            .dir      (dir[ch])
        );

        // velocity from the counter's step pulse
        enc_period_meter #(
            .FREQ_WINDOW (FREQ_WINDOW)
        ) meter (
            .sysclk    (sysclk),
            .reset     (reset),
            .step      (step[ch]),
            .dir       (dir[ch]),
            .period    (period[ch]),
            .frequency (frequency[ch])
        );
    end

    // ------------------------------------------------------------------------
    // host register port

    enc_reg_file #(
        .NUM_CHAN (NUM_CHAN)
    ) reg_file (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .position  (position),
        .period    (period),
        .frequency (frequency),
        .preload   (preload),
        .load      (load)
    );

endmodule

// File: logic/enc_debounce.sv
// encoder line synchronizer and filter

module enc_debounce #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic sysclk,
    input  logic reset,
    input  logic line_raw,          // asynchronous encoder line
    output logic line_filt          // synchronized, glitch free
);
    import enc_pkg::*;

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] SETTLE_END = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [1:0]       sync_q;       // two-flop synchronizer
    logic             line_diff;    // synchronized line disagrees with output
    logic             settle_done;  // this is the last differing cycle needed
    logic [CNT_W-1:0] settle_cnt;   // differing cycles seen so far
    filt_state_t      state;

    assign line_diff   = (sync_q[1] != line_filt);
    assign settle_done = (settle_cnt == SETTLE_END);

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            sync_q     <= '0;
            line_filt  <= 1'b0;
            settle_cnt <= '0;
            state      <= FILT_STABLE;
        end
        else
        begin
            sync_q <= {sync_q[0], line_raw};
            case (state)
                FILT_STABLE:
                begin
                    // settle count is zero whenever output is stable
                    if (line_diff)
                    begin
                        if (settle_done)
                            line_filt <= sync_q[1];     // one-cycle filter
                        else
                        begin
                            settle_cnt <= settle_cnt + 1'b1;
                            state      <= FILT_SETTLING;
                        end
                    end
                end
                FILT_SETTLING:
                begin
                    if (!line_diff)
                    begin                           // glitch gone, start over
                        settle_cnt <= '0;
                        state      <= FILT_STABLE;
                    end
                    else if (settle_done)
                    begin                           // held long enough
                        line_filt  <= sync_q[1];
                        settle_cnt <= '0;
                        state      <= FILT_STABLE;
                    end
                    else
                    begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                default: state <= FILT_STABLE;
            endcase
        end
    end

    // output may only move after a full run of differing cycles
    a_filt_settled: assert property (@(posedge sysclk) disable iff (!reset)
        !$stable(line_filt) |-> $past(settle_done && line_diff))
        else $error("line_filt changed before settle count ended");

endmodule

// File: logic/enc_period_meter.sv
// step period and windowed step count

module enc_period_meter #(
    parameter int FREQ_WINDOW = 1024
) (
    input  logic           sysclk,
    input  logic           reset,
    input  logic           step,        // one-cycle step pulse
    input  logic           dir,         // direction, valid with step
    output enc_pkg::meas_t period,      // {dir, cycles between steps}
    output enc_pkg::meas_t frequency    // steps in last full window
);
    import enc_pkg::*;

    localparam int WIN_W = (FREQ_WINDOW > 1) ? $clog2(FREQ_WINDOW) : 1;
    localparam logic [WIN_W-1:0] WIN_END = WIN_W'(FREQ_WINDOW - 1);

    logic [30:0]      per_cnt;      // cycles since last step
    logic [WIN_W-1:0] win_cnt;      // position inside window
    logic             win_end;      // last cycle of window
    meas_t            step_acc;     // steps so far in this window

    assign win_end = (win_cnt == WIN_END);

    // ------------------------------------------------------------------------
    // period between steps

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            per_cnt <= '0;
            period  <= '0;
        end
        else if (step)
        begin
            period  <= {dir, per_cnt};  // count equals step spacing here
            per_cnt <= 31'd1;           // this cycle counts toward next one
        end
        else if (per_cnt != PERIOD_MAX)
        begin
            per_cnt <= per_cnt + 31'd1;
        end
    end

    // ------------------------------------------------------------------------
    // steps per fixed window

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            win_cnt   <= '0;
            step_acc  <= '0;
            frequency <= '0;
        end
        else
        begin
            if (win_end)
            begin
                win_cnt   <= '0;
                frequency <= step_acc + meas_t'(step);  // include final cycle
                step_acc  <= '0;
            end
            else
            begin
                win_cnt  <= win_cnt + 1'b1;
                step_acc <= step_acc + meas_t'(step);
            end
        end
    end

    // counter saturates on a stalled encoder and never wraps
    a_period_sat: assert property (@(posedge sysclk) disable iff (!reset)
        (per_cnt == PERIOD_MAX && !step) |=> (per_cnt == PERIOD_MAX))
        else $error("period cycle counter ran past PERIOD_MAX");

endmodule

// File: logic/enc_pkg.sv
// encoder interface shared definitions

package enc_pkg;

    // -------------------------------------------------------------------------
    // data widths

    typedef logic [23:0] count_t;       // position counter value
    typedef logic [24:0] quad_t;        // overflow bit on top of count
    typedef logic [31:0] meas_t;        // period or frequency measurement
    typedef logic [15:0] reg_addr_t;    // register file address
    typedef logic [31:0] reg_data_t;    // register file data
    typedef logic [3:0]  chan_idx_t;    // channel index, addr bits 7:4

    // -------------------------------------------------------------------------
    // register map

    // address space of the encoder block, addr bits 15:12
    localparam logic [3:0] ADDR_MAIN = 4'h0;

    // per-channel offsets, addr bits 3:0
    localparam logic [3:0] OFF_ENC_LOAD  = 4'h0;    // counter preload
    localparam logic [3:0] OFF_ENC_DATA  = 4'h1;    // position with overflow
    localparam logic [3:0] OFF_PER_DATA  = 4'h2;    // step period
    localparam logic [3:0] OFF_FREQ_DATA = 4'h3;    // steps per window

    // -------------------------------------------------------------------------
    // reset and limit values

    // counter starts at half scale so either direction has full range
    localparam count_t PRELOAD_RESET = 24'h800000;

    // period cycle count holds here on a stalled encoder
    localparam logic [30:0] PERIOD_MAX = 31'h7fffffff;

    // -------------------------------------------------------------------------
    // debounce state machine

    typedef enum logic
    {
        FILT_STABLE,        // output matches synchronized line
        FILT_SETTLING       // line differs, waiting for it to hold
    } filt_state_t;

endpackage

// File: logic/enc_quad_counter.sv
// quadrature decoder and position counter

module enc_quad_counter (
    input  logic            sysclk,
    input  logic            reset,
    input  logic            a_filt,     // filtered encoder A
    input  logic            b_filt,     // filtered encoder B
    input  logic            load,       // one-cycle preload strobe
    input  enc_pkg::count_t preload,    // value loaded on strobe
    output enc_pkg::quad_t  position,   // {overflow, count}
    output logic            step,       // one cycle per valid transition
    output logic            dir         // 1 = forward, A leads B
);
    import enc_pkg::*;

    logic   a_prev;         // pair from last cycle
    logic   b_prev;
    logic   a_chg;
    logic   b_chg;
    logic   both_chg;       // illegal jump, two lines at once
    logic   fwd;            // valid forward transition
    logic   bwd;            // valid backward transition
    count_t count;
    logic   overflow;       // sticky wrap flag

    // ------------------------------------------------------------------------
    // transition decode

    assign a_chg    = a_filt ^ a_prev;
    assign b_chg    = b_filt ^ b_prev;
    assign both_chg = a_chg & b_chg;

    // forward sequence 00 -> 10 -> 11 -> 01 -> 00
    // A moving away from B, or B catching up with A
    assign fwd = (a_chg & ~b_chg & (a_filt ^ b_filt))
               | (b_chg & ~a_chg & ~(a_filt ^ b_filt));
    assign bwd = (a_chg ^ b_chg) & ~fwd;    // any other single-line change

    // ------------------------------------------------------------------------
    // step pulse, direction and counter

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            a_prev   <= 1'b0;
            b_prev   <= 1'b0;
            step     <= 1'b0;
            dir      <= 1'b0;
            count    <= PRELOAD_RESET;
            overflow <= 1'b0;
        end
        else
        begin
            a_prev <= a_filt;
            b_prev <= b_filt;
            step   <= fwd | bwd;
            if (fwd | bwd)
                dir <= fwd;             // hold last direction between steps

            if (load)
            begin                       // preload wins over a step
                count    <= preload;
                overflow <= 1'b0;
            end
            else if (fwd)
            begin
                count <= count + 1'b1;
                if (count == '1)
                    overflow <= 1'b1;   // wrapped past top
            end
            else if (bwd)
            begin
                count <= count - 1'b1;
                if (count == '0)
                    overflow <= 1'b1;   // wrapped past zero
            end
        end
    end

    assign position = {overflow, count};

    a_no_double_step: assert property (@(posedge sysclk) disable iff (!reset)
        both_chg |=> !step)
        else $error("step raised on a two-line transition");

endmodule

// File: logic/enc_reg_file.sv
// encoder register file port

module enc_reg_file #(
    parameter int NUM_CHAN = 4
) (
    input  logic                           sysclk,
    input  logic                           reset,
    input  enc_pkg::reg_addr_t             reg_raddr,  // read address
    output enc_pkg::reg_data_t             reg_rdata,  // read data, combinational
    input  enc_pkg::reg_addr_t             reg_waddr,  // write address
    input  enc_pkg::reg_data_t             reg_wdata,  // write data
    input  logic                           reg_wen,    // single-cycle write strobe
    input  enc_pkg::quad_t  [NUM_CHAN-1:0] position,
    input  enc_pkg::meas_t  [NUM_CHAN-1:0] period,
    input  enc_pkg::meas_t  [NUM_CHAN-1:0] frequency,
    output enc_pkg::count_t [NUM_CHAN-1:0] preload,    // per-channel preload regs
    output logic            [NUM_CHAN-1:0] load        // counter load pulses
);
    import enc_pkg::*;

    chan_idx_t wr_chan;     // channel targeted by write
    chan_idx_t rd_chan;     // channel targeted by read
    logic      wr_load;     // write hits a preload offset in our space

    assign wr_chan = reg_waddr[7:4];
    assign rd_chan = reg_raddr[7:4];
    assign wr_load = reg_wen
                  && (reg_waddr[15:12] == ADDR_MAIN)
                  && (reg_waddr[3:0] == OFF_ENC_LOAD);

    // ------------------------------------------------------------------------
    // preload write and load pulse

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            preload <= {NUM_CHAN{PRELOAD_RESET}};   // half scale
            load    <= '0;
        end
        else
        begin
            load <= '0;                             // pulse lasts one cycle
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                // channels past NUM_CHAN never match, write is dropped
                if (wr_load && (wr_chan == chan_idx_t'(i)))
                begin
                    preload[i] <= reg_wdata[23:0];
                    load[i]    <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read multiplexer
    // address space bits are not decoded on reads

    always_comb
    begin
        reg_rdata = '0;                             // unknown offset or channel
        for (int i = 0; i < NUM_CHAN; i++)
        begin
            if (rd_chan == chan_idx_t'(i))
            begin
                case (reg_raddr[3:0])
                    OFF_ENC_LOAD:  reg_rdata = reg_data_t'(preload[i]);
                    OFF_ENC_DATA:  reg_rdata = reg_data_t'(position[i]);
                    OFF_PER_DATA:  reg_rdata = period[i];
                    OFF_FREQ_DATA: reg_rdata = frequency[i];
                    default:       reg_rdata = '0;
                endcase
            end
        end
    end

    // a load pulse only follows a write, and only one channel at a time
    a_load_onehot: assert property (@(posedge sysclk) disable iff (!reset)
        (|load) |-> ($onehot0(load) && $past(reg_wen)))
        else $error("load pulse without write or on several channels");

endmodule

// File: run_sim.sh
#!/bin/bash
# compile and run the encoder interface testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module tb_ctrl_enc \
    -f ctrl_enc.f \
    --Mdir obj_dir -o sim_ctrl_enc

./obj_dir/sim_ctrl_enc | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

// File: testbench/tb_clock_gen.sv
// testbench clock and reset

module tb_clock_gen (
    output logic sysclk,
    output logic reset              // active low
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;

    initial
    begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;    // 10 ns period
    end

    initial
    begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #1 reset = 1'b1;                // release just after an edge
    end

endmodule

// File: testbench/tb_ctrl_enc.sv
// encoder interface testbench

module tb_ctrl_enc;
    timeunit 1ns;
    timeprecision 100ps;
    import enc_pkg::*;

    localparam int NUM_CHAN        = 4;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int FREQ_WINDOW     = 1024;
    localparam int HOLD_MIN        = 3 * DEBOUNCE_CYCLES;
    localparam int HOLD_MAX        = 60;
    localparam int STEP_TIMEOUT    = 40;        // cycles for a step to reach the count

    logic                sysclk;
    logic                reset;
    logic [NUM_CHAN-1:0] enc_a;
    logic [NUM_CHAN-1:0] enc_b;
    reg_addr_t           reg_raddr;
    reg_data_t           reg_rdata;
    reg_addr_t           reg_waddr;
    reg_data_t           reg_wdata;
    logic                reg_wen;

    // reference model, one entry per channel
    logic [1:0] phase [NUM_CHAN];               // gray phase, AB = 00 10 11 01
    count_t     exp_count [NUM_CHAN];
    logic       exp_ovf [NUM_CHAN];
    count_t     exp_preload [NUM_CHAN];
    int         last_hold [NUM_CHAN];           // cycles the last step was held

    int seed;
    int err_count;
    int test_base;                              // err_count at start of test
    int tests_ok;
    int tests_bad;

    tb_clock_gen clock_gen (
        .sysclk (sysclk),
        .reset  (reset)
    );

    ctrl_enc #(
        .NUM_CHAN        (NUM_CHAN),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .FREQ_WINDOW     (FREQ_WINDOW)
    ) ctrl_enc_inst (
        .sysclk    (sysclk),
        .reset     (reset),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen)
    );

    // ------------------------------------------------------------------------
    // helpers

    function automatic reg_addr_t chan_addr(input int ch, input logic [3:0] off);
        return {ADDR_MAIN, 4'h0, 4'(ch), off};
    endfunction

    function automatic reg_data_t quad_word(input int ch);
        return {7'h0, exp_ovf[ch], exp_count[ch]};  // overflow above count
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge sysclk);
        #1;                                     // drive point after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act)
        begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    // combinational read, one cycle per access
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_raddr = addr;
        #1;
        data = reg_rdata;
        tick(1);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        tick(1);                                // write edge
        reg_wen   = 1'b0;
    endtask

    // preload a channel, then check the register and the counter
    task automatic load_chan(input int ch, input reg_data_t wdata);
        reg_data_t rd;
        write_reg(chan_addr(ch, OFF_ENC_LOAD), wdata);
        exp_preload[ch] = wdata[23:0];          // upper bits not stored
        exp_count[ch]   = wdata[23:0];
        exp_ovf[ch]     = 1'b0;                 // load clears overflow
        read_reg(chan_addr(ch, OFF_ENC_LOAD), rd);
        check_value("preload", {8'h0, exp_preload[ch]}, rd);
        read_reg(chan_addr(ch, OFF_ENC_DATA), rd);  // second cycle after the write
        check_value("position", quad_word(ch), rd);
    endtask

    task automatic check_positions();
        reg_data_t rd;
        for (int ch = 0; ch < NUM_CHAN; ch++)
        begin
            read_reg(chan_addr(ch, OFF_ENC_DATA), rd);
            check_value($sformatf("position[%0d]", ch), quad_word(ch), rd);
        end
    endtask

    // one gray step, wait for the count, then hold the phase
    task automatic step_chan(input int ch, input logic fwd, input int hold);
        reg_data_t rd;
        int        waited;
        logic      seen;
        if (fwd)
        begin
            phase[ch]     = phase[ch] + 2'd1;
            exp_ovf[ch]   = exp_ovf[ch] | (exp_count[ch] == '1);    // wrap past top
            exp_count[ch] = exp_count[ch] + 24'd1;
        end
        else
        begin
            phase[ch]     = phase[ch] - 2'd1;
            exp_ovf[ch]   = exp_ovf[ch] | (exp_count[ch] == '0);    // wrap past zero
            exp_count[ch] = exp_count[ch] - 24'd1;
        end
        enc_a[ch] = ^phase[ch];
        enc_b[ch] = phase[ch][1];
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < STEP_TIMEOUT)
        begin
            read_reg(chan_addr(ch, OFF_ENC_DATA), rd);
            seen = (rd == quad_word(ch));
            waited++;
        end
        if (!seen)
        begin
            $display("timeout: channel %0d count never reached %h", ch, quad_word(ch));
            err_count++;
        end
        else if (hold > waited)
            tick(hold - waited);                // edge spacing is exactly hold
        last_hold[ch] = hold;
    endtask

    // pulse one raw line for len cycles, position must hold every cycle
    task automatic glitch_line(input int ch, input logic on_b, input int len);
        reg_data_t rd;
        for (int i = 0; i < 2; i++)
        begin
            if (on_b)
                enc_b[ch] = ~enc_b[ch];
            else
                enc_a[ch] = ~enc_a[ch];
            for (int c = 0; c < ((i == 0) ? len : HOLD_MIN); c++)
            begin
                read_reg(chan_addr(ch, OFF_ENC_DATA), rd);
                check_value($sformatf("position[%0d]", ch), quad_word(ch), rd);
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (err_count == test_base)
        begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            tests_bad++;
            $display("test %0d %s: %0d errors", num, name, err_count - test_base);
        end
        test_base = err_count;
    endtask

    // ------------------------------------------------------------------------
    // test sequence

    initial
    begin
        reg_data_t rd;
        int        ch;
        int        hold;
        int        n;
        int        lo;
        int        hi;
        logic      d;
        seed      = 32'h3c9a;
        enc_a     = '0;
        enc_b     = '0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        err_count = 0;
        test_base = 0;
        tests_ok  = 0;
        tests_bad = 0;
        for (ch = 0; ch < NUM_CHAN; ch++)
        begin
            phase[ch]       = 2'd0;
            exp_count[ch]   = PRELOAD_RESET;
            exp_ovf[ch]     = 1'b0;
            exp_preload[ch] = PRELOAD_RESET;
            last_hold[ch]   = 0;
        end

        n = 0;
        while (reset !== 1'b1 && n < 100)
        begin
            @(posedge sysclk);
            n++;
        end
        if (reset !== 1'b1)
        begin
            $display("timeout: reset was never released");
            err_count++;
        end
        tick(2);

        // 1: reset values, unknown offsets and channels read zero
        for (ch = 0; ch < NUM_CHAN; ch++)
        begin
            read_reg(chan_addr(ch, OFF_ENC_LOAD), rd);
            check_value("preload", {8'h0, PRELOAD_RESET}, rd);
            read_reg(chan_addr(ch, OFF_ENC_DATA), rd);
            check_value("position", quad_word(ch), rd);
            read_reg(chan_addr(ch, OFF_PER_DATA), rd);
            check_value("period", 32'h0, rd);
            read_reg(chan_addr(ch, OFF_FREQ_DATA), rd);
            check_value("frequency", 32'h0, rd);
            for (int off = 4; off < 16; off++)
            begin
                read_reg(chan_addr(ch, 4'(off)), rd);
                check_value("reg_rdata", 32'h0, rd);
            end
        end
        read_reg(chan_addr(NUM_CHAN, OFF_ENC_DATA), rd);
        check_value("reg_rdata", 32'h0, rd);
        end_test(1, "reset values");

        // 2: random preloads; stray writes must change nothing
        for (int i = 0; i < 8; i++)
        begin
            ch = rand_range(0, NUM_CHAN - 1);
            load_chan(ch, $random(seed));
            check_positions();
        end
        write_reg(chan_addr(NUM_CHAN, OFF_ENC_LOAD), 32'h00123456);
        write_reg({4'h1, 4'h0, 4'h0, OFF_ENC_LOAD}, 32'h00654321);  // other space
        tick(2);
        check_positions();
        read_reg(chan_addr(0, OFF_ENC_LOAD), rd);
        check_value("preload[0]", {8'h0, exp_preload[0]}, rd);
        end_test(2, "preload");

        // 3: wrap at both ends, then a random walk on all channels
        load_chan(0, 32'h00fffffe);
        load_chan(1, 32'h00000001);
        for (int i = 0; i < 3; i++)
        begin
            step_chan(0, 1'b1, rand_range(HOLD_MIN, HOLD_MAX));
            step_chan(1, 1'b0, rand_range(HOLD_MIN, HOLD_MAX));
        end
        check_positions();
        for (int i = 0; i < 32; i++)
        begin
            ch = rand_range(0, NUM_CHAN - 1);
            d  = (rand_range(0, 1) == 1);
            step_chan(ch, d, rand_range(HOLD_MIN, HOLD_MAX));
        end
        check_positions();
        end_test(3, "counting");

        // 4: period of two back to back steps
        for (ch = 0; ch < NUM_CHAN; ch++)
        begin
            d = (rand_range(0, 1) == 1);
            step_chan(ch, ~d, rand_range(HOLD_MIN, HOLD_MAX));
            hold = last_hold[ch];
            step_chan(ch, d, rand_range(HOLD_MIN, HOLD_MAX));
            read_reg(chan_addr(ch, OFF_PER_DATA), rd);
            check_value($sformatf("period[%0d]", ch), {d, 31'(hold)}, rd);
        end
        end_test(4, "period");

        // 5: short glitches and two-line jumps are not counted
        for (ch = 0; ch < NUM_CHAN; ch++)
        begin
            glitch_line(ch, 1'b0, rand_range(1, DEBOUNCE_CYCLES - 1));
            glitch_line(ch, 1'b1, rand_range(1, DEBOUNCE_CYCLES - 1));
            phase[ch] = phase[ch] + 2'd2;       // both lines flip
            enc_a[ch] = ^phase[ch];
            enc_b[ch] = phase[ch][1];
            tick(HOLD_MIN);
        end
        check_positions();
        step_chan(0, 1'b1, HOLD_MIN);           // decoder still tracks the new phase
        check_positions();
        end_test(5, "glitch reject");

        // 6: steps at a fixed interval, then an idle window
        hold = rand_range(HOLD_MIN, 31);
        n    = (2 * FREQ_WINDOW) / hold + 2;    // covers one full window
        for (int i = 0; i < n; i++)
            step_chan(2, 1'b1, hold);
        read_reg(chan_addr(2, OFF_FREQ_DATA), rd);
        lo = FREQ_WINDOW / hold;
        hi = (FREQ_WINDOW + hold - 1) / hold;
        check_value("frequency", (rd == reg_data_t'(hi)) ? hi : lo, rd);
        tick(2 * FREQ_WINDOW + 16);
        read_reg(chan_addr(2, OFF_FREQ_DATA), rd);
        check_value("frequency", 32'h0, rd);
        end_test(6, "frequency");

        $display("tests ok: %0d, with errors: %0d", tests_ok, tests_bad);
        if (err_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
